// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
SEED      ?= 3
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
common/rv_pkg.sv
common/rv_stage_if.sv
frontend/rv_fetch_decode.sv
logic/rv_operand_stage.sv
execute/rv_execute.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

// File: common/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc  = '0;
    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes accepted by the decoder
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // Execute stage operations
    localparam int uop_w = 5;
    localparam logic [uop_w-1:0] uop_add  = 5'd0;
    localparam logic [uop_w-1:0] uop_sub  = 5'd1;
    localparam logic [uop_w-1:0] uop_and  = 5'd2;
    localparam logic [uop_w-1:0] uop_or   = 5'd3;
    localparam logic [uop_w-1:0] uop_xor  = 5'd4;
    localparam logic [uop_w-1:0] uop_sll  = 5'd5;
    localparam logic [uop_w-1:0] uop_srl  = 5'd6;
    localparam logic [uop_w-1:0] uop_sra  = 5'd7;
    localparam logic [uop_w-1:0] uop_slt  = 5'd8;
    localparam logic [uop_w-1:0] uop_sltu = 5'd9;
    localparam logic [uop_w-1:0] uop_beq  = 5'd10;
    localparam logic [uop_w-1:0] uop_bne  = 5'd11;
    localparam logic [uop_w-1:0] uop_blt  = 5'd12;
    localparam logic [uop_w-1:0] uop_bge  = 5'd13;
    localparam logic [uop_w-1:0] uop_jal  = 5'd14;
    localparam logic [uop_w-1:0] uop_sw   = 5'd15;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } rv_s_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } rv_b_t;

    // One instruction word, four ways of reading it
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
    } rv_instr_u;

endpackage

// File: common/rv_stage_if.sv
`timescale 1ns/10ps

// Front end to operand stage
interface decode_if;
    logic                          valid;
    logic [rv_pkg::uop_w-1:0]      uop;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic                          rd_valid;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::xlen-1:0]       pc;

    modport producer (output valid, uop, rd, rd_valid, rs1, rs2, imm, pc);
    modport consumer (input valid, uop, rd, rd_valid, rs1, rs2, imm, pc);
endinterface

// Operand stage to execute stage
interface issue_if;
    logic                          valid;
    logic [rv_pkg::uop_w-1:0]      uop;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic                          rd_valid;
    logic [rv_pkg::xlen-1:0]       rs1_value;
    logic [rv_pkg::xlen-1:0]       rs2_value;
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::xlen-1:0]       pc;

    modport producer (output valid, uop, rd, rd_valid, rs1_value, rs2_value, imm, pc);
    modport consumer (input valid, uop, rd, rd_valid, rs1_value, rs2_value, imm, pc);
endinterface

// File: execute/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  logic                          clk,
    input  logic                          arst_n,
    issue_if.consumer                     iss,
    output logic                          wb_en,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          redirect,
    output logic [rv_pkg::xlen-1:0]       redirect_pc,
    output logic                          mem_wr_en,
    output logic [rv_pkg::xlen-1:0]       mem_wr_addr,
    output logic [rv_pkg::xlen-1:0]       mem_wr_data
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;
    logic [rv_pkg::xlen-1:0] result;
    logic                    taken;
    logic                    is_store;

    assign op_a = iss.rs1_value;
    // Immediate forms arrive with rs2 as x0, so a zero imm means register form
    assign op_b  = (iss.imm != '0) ? iss.imm : iss.rs2_value;
    assign shamt = op_b[4:0];

    always_comb begin
        case (iss.uop)
            rv_pkg::uop_add:  result = op_a + op_b;
            rv_pkg::uop_sub:  result = op_a - op_b;
            rv_pkg::uop_and:  result = op_a & op_b;
            rv_pkg::uop_or:   result = op_a | op_b;
            rv_pkg::uop_xor:  result = op_a ^ op_b;
            rv_pkg::uop_sll:  result = op_a << shamt;
            rv_pkg::uop_srl:  result = op_a >> shamt;
            rv_pkg::uop_sra:  result = $signed(op_a) >>> shamt;
            rv_pkg::uop_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pkg::uop_sltu: result = {31'd0, op_a < op_b};
            // Link value
            rv_pkg::uop_jal:  result = iss.pc + 32'd4;
            default:          result = '0;
        endcase
    end

    always_comb begin
        case (iss.uop)
            rv_pkg::uop_beq: taken = iss.rs1_value == iss.rs2_value;
            rv_pkg::uop_bne: taken = iss.rs1_value != iss.rs2_value;
            rv_pkg::uop_blt: taken = $signed(iss.rs1_value) < $signed(iss.rs2_value);
            rv_pkg::uop_bge: taken = $signed(iss.rs1_value) >= $signed(iss.rs2_value);
            rv_pkg::uop_jal: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign redirect    = iss.valid && taken;
    assign redirect_pc = iss.pc + iss.imm;

    assign wb_en   = iss.valid && iss.rd_valid;
    assign wb_rd   = iss.rd;
    assign wb_data = result;

    assign is_store = iss.valid && iss.uop == rv_pkg::uop_sw;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mem_wr_en <= 1'b0;
        else
            mem_wr_en <= is_store;
    end

    always_ff @(posedge clk) begin
        if (is_store) begin
            mem_wr_addr <= iss.rs1_value + iss.imm;
            mem_wr_data <= iss.rs2_value;
        end
    end

    // A store never carries a destination register
    a_store_no_wb: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_en |=> !mem_wr_en
    );

endmodule

// File: frontend/rv_fetch_decode.sv
`timescale 1ns/10ps

module rv_fetch_decode (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [rv_pkg::xlen-1:0] instr,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    output logic [rv_pkg::xlen-1:0] pc,
    decode_if.producer              dec
);

    logic                    fetch_valid;
    logic [rv_pkg::xlen-1:0] fetch_word;
    logic [rv_pkg::xlen-1:0] fetch_pc;
    rv_pkg::rv_instr_u       iw;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= rv_pkg::reset_pc;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= redirect ? redirect_pc : pc + 32'd4;
            fetch_valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        fetch_word <= redirect ? rv_pkg::nop_instr : instr;
        fetch_pc   <= pc;
    end

    assign iw     = fetch_word;
    assign dec.pc = fetch_pc;

    // Immediate forms read x0 as rs2, register forms carry a zero immediate
    always_comb begin
        dec.valid    = 1'b0;
        dec.uop      = rv_pkg::uop_add;
        dec.rd       = iw.r.rd;
        dec.rd_valid = 1'b0;
        dec.rs1      = iw.r.rs1;
        dec.rs2      = iw.r.rs2;
        dec.imm      = '0;
        case (iw.r.opcode)
            rv_pkg::opc_op: begin
                dec.valid    = fetch_valid && (iw.r.funct7 == 7'h00 ||
                               (iw.r.funct7 == 7'h20 &&
                                (iw.r.funct3 == 3'b000 || iw.r.funct3 == 3'b101)));
                dec.rd_valid = iw.r.rd != '0;
                case (iw.r.funct3)
                    3'b000:  dec.uop = iw.r.funct7[5] ? rv_pkg::uop_sub : rv_pkg::uop_add;
                    3'b001:  dec.uop = rv_pkg::uop_sll;
                    3'b010:  dec.uop = rv_pkg::uop_slt;
                    3'b011:  dec.uop = rv_pkg::uop_sltu;
                    3'b100:  dec.uop = rv_pkg::uop_xor;
                    3'b101:  dec.uop = iw.r.funct7[5] ? rv_pkg::uop_sra : rv_pkg::uop_srl;
                    3'b110:  dec.uop = rv_pkg::uop_or;
                    default: dec.uop = rv_pkg::uop_and;
                endcase
            end
            rv_pkg::opc_op_imm: begin
                dec.valid    = fetch_valid;
                dec.rd_valid = iw.i.rd != '0;
                dec.rs2      = '0;
                dec.imm      = {{20{iw.i.imm[11]}}, iw.i.imm};
                case (iw.i.funct3)
                    3'b000:  dec.uop = rv_pkg::uop_add;
                    3'b001:  dec.uop = rv_pkg::uop_sll;
                    3'b010:  dec.uop = rv_pkg::uop_slt;
                    3'b011:  dec.uop = rv_pkg::uop_sltu;
                    3'b100:  dec.uop = rv_pkg::uop_xor;
                    3'b101:  dec.uop = iw.r.funct7[5] ? rv_pkg::uop_sra : rv_pkg::uop_srl;
                    3'b110:  dec.uop = rv_pkg::uop_or;
                    default: dec.uop = rv_pkg::uop_and;
                endcase
            end
            rv_pkg::opc_branch: begin
                dec.imm = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                           iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
                case (iw.b.funct3)
                    3'b000: begin
                        dec.valid = fetch_valid;
                        dec.uop   = rv_pkg::uop_beq;
                    end
                    3'b001: begin
                        dec.valid = fetch_valid;
                        dec.uop   = rv_pkg::uop_bne;
                    end
                    3'b100: begin
                        dec.valid = fetch_valid;
                        dec.uop   = rv_pkg::uop_blt;
                    end
                    3'b101: begin
                        dec.valid = fetch_valid;
                        dec.uop   = rv_pkg::uop_bge;
                    end
                    default: dec.valid = 1'b0;
                endcase
            end
            rv_pkg::opc_jal: begin
                dec.valid    = fetch_valid;
                dec.uop      = rv_pkg::uop_jal;
                dec.rd_valid = iw.i.rd != '0;
                // J-format bits land in the I view fields
                dec.imm      = {{11{iw.i.imm[11]}}, iw.i.imm[11], iw.i.rs1, iw.i.funct3,
                                iw.i.imm[0], iw.i.imm[10:1], 1'b0};
            end
            rv_pkg::opc_store: begin
                dec.valid = fetch_valid && iw.s.funct3 == 3'b010;
                dec.uop   = rv_pkg::uop_sw;
                dec.imm   = {{20{iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
            end
            default: dec.valid = 1'b0;
        endcase
    end

    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect |-> redirect_pc[1:0] == 2'b00
    );

endmodule

// File: logic/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    mem_wr_en,
    output logic [rv_pkg::xlen-1:0] mem_wr_addr,
    output logic [rv_pkg::xlen-1:0] mem_wr_data
);

    logic                          wb_en;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;
    logic                          redirect;
    logic [rv_pkg::xlen-1:0]       redirect_pc;

    decode_if dec_link ();
    issue_if  iss_link ();

    rv_fetch_decode fetch_decode_inst0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .dec         (dec_link.producer)
    );

    rv_operand_stage operand_stage_inst0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .dec      (dec_link.consumer),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .redirect (redirect),
        .iss      (iss_link.producer)
    );

    rv_execute execute_inst0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .iss         (iss_link.consumer),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

endmodule

// File: logic/rv_operand_stage.sv
`timescale 1ns/10ps

module rv_operand_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    decode_if.consumer                    dec,
    input  logic                          wb_en,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]       wb_data,
    input  logic                          redirect,
    issue_if.producer                     iss
);

    logic [rv_pkg::xlen-1:0] regs [1:31];
    logic [rv_pkg::xlen-1:0] rs1_value;
    logic [rv_pkg::xlen-1:0] rs2_value;

    // x0 is hard zero, a same-cycle write passes straight through
    function automatic logic [rv_pkg::xlen-1:0] read_port(
        input logic [rv_pkg::reg_addr_w-1:0] idx
    );
        if (idx == '0)
            return '0;
        else if (wb_en && wb_rd == idx)
            return wb_data;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_en)
            regs[wb_rd] <= wb_data;
    end

    always_comb begin
        rs1_value = read_port(dec.rs1);
        rs2_value = read_port(dec.rs2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            iss.valid <= 1'b0;
        else
            iss.valid <= dec.valid && !redirect;
    end

    always_ff @(posedge clk) begin
        iss.uop       <= dec.uop;
        iss.rd        <= dec.rd;
        iss.rd_valid  <= dec.rd_valid;
        iss.rs1_value <= rs1_value;
        iss.rs2_value <= rs2_value;
        iss.imm       <= dec.imm;
        iss.pc        <= dec.pc;
    end

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_en |-> wb_rd != '0
    );

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    localparam int store_timeout = 40;

    logic                    clk;
    logic                    arst_n = 1'b0;
    logic [rv_pkg::xlen-1:0] instr = rv_pkg::nop_instr;
    logic [rv_pkg::xlen-1:0] pc;
    logic                    mem_wr_en;
    logic [rv_pkg::xlen-1:0] mem_wr_addr;
    logic [rv_pkg::xlen-1:0] mem_wr_data;

    logic [rv_pkg::xlen-1:0] prog [$];
    logic [rv_pkg::xlen-1:0] exp_addr [$];
    logic [rv_pkg::xlen-1:0] exp_data [$];
    int                      next_off;

    rv_core dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .pc          (pc),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [rv_pkg::xlen-1:0] r_type(input logic [6:0] f7,
        input logic [2:0] f3, input int rd, input int rs1, input int rs2);
        rv_pkg::rv_instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2[4:0];
        w.r.rs1    = rs1[4:0];
        w.r.funct3 = f3;
        w.r.rd     = rd[4:0];
        w.r.opcode = rv_pkg::opc_op;
        return w;
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] i_type(input logic [2:0] f3,
        input int rd, input int rs1, input int imm);
        rv_pkg::rv_instr_u w;
        w.i.imm    = imm[11:0];
        w.i.rs1    = rs1[4:0];
        w.i.funct3 = f3;
        w.i.rd     = rd[4:0];
        w.i.opcode = rv_pkg::opc_op_imm;
        return w;
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] s_type(input int rs1, input int rs2,
        input int off);
        rv_pkg::rv_instr_u w;
        w.s.imm_11_5 = off[11:5];
        w.s.rs2      = rs2[4:0];
        w.s.rs1      = rs1[4:0];
        w.s.funct3   = 3'b010;
        w.s.imm_4_0  = off[4:0];
        w.s.opcode   = rv_pkg::opc_store;
        return w;
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] b_type(input logic [2:0] f3,
        input int rs1, input int rs2, input int off);
        rv_pkg::rv_instr_u w;
        w.b.imm_12   = off[12];
        w.b.imm_10_5 = off[10:5];
        w.b.rs2      = rs2[4:0];
        w.b.rs1      = rs1[4:0];
        w.b.funct3   = f3;
        w.b.imm_4_1  = off[4:1];
        w.b.imm_11   = off[11];
        w.b.opcode   = rv_pkg::opc_branch;
        return w;
    endfunction

    // J format: imm[20|10:1|11|19:12], rd, opcode
    function automatic logic [rv_pkg::xlen-1:0] jal_word(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::opc_jal};
    endfunction

    function automatic logic [rv_pkg::xlen-1:0] word_at(input logic [rv_pkg::xlen-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog.size())
            return prog[idx];
        return rv_pkg::nop_instr;
    endfunction

    // SW of a register to the next slot above the base in x10
    task automatic store_reg(input int rs2, input logic [rv_pkg::xlen-1:0] exp);
        prog.push_back(s_type(10, rs2, next_off));
        exp_addr.push_back(32'h100 + next_off);
        exp_data.push_back(exp);
        next_off += 4;
    endtask

    task automatic alu_case(input logic [6:0] f7, input logic [2:0] f3, input int rs1,
        input int rs2, input logic [rv_pkg::xlen-1:0] exp);
        prog.push_back(r_type(f7, f3, 3, rs1, rs2));
        store_reg(3, exp);
    endtask

    // Both skipped stores would land at 0x300, which no expected entry holds
    task automatic taken_skip(input logic [2:0] f3, input int rs1, input int rs2);
        prog.push_back(b_type(f3, rs1, rs2, 12));
        prog.push_back(s_type(10, 3, 'h200));
        prog.push_back(s_type(10, 3, 'h200));
    endtask

    task automatic build_program();
        int                      a;
        int                      b;
        int                      at;
        logic [rv_pkg::xlen-1:0] va;
        logic [rv_pkg::xlen-1:0] vb;
        a  = int'($urandom % 2048);
        b  = -1 - int'($urandom % 2048);
        va = a;
        vb = b;
        next_off = 0;
        prog.push_back(i_type(3'b000, 10, 0, 'h100));
        prog.push_back(i_type(3'b000, 1, 0, a));
        prog.push_back(i_type(3'b000, 2, 0, b));
        store_reg(1, va);
        store_reg(2, vb);
        alu_case(7'h00, 3'b000, 1, 2, va + vb);
        alu_case(7'h20, 3'b000, 1, 2, va - vb);
        alu_case(7'h00, 3'b111, 1, 2, va & vb);
        alu_case(7'h00, 3'b110, 1, 2, va | vb);
        alu_case(7'h00, 3'b100, 1, 2, va ^ vb);
        alu_case(7'h00, 3'b001, 1, 2, va << vb[4:0]);
        alu_case(7'h00, 3'b101, 1, 2, va >> vb[4:0]);
        alu_case(7'h20, 3'b101, 2, 1, $signed(vb) >>> va[4:0]);
        alu_case(7'h00, 3'b010, 2, 1, 32'd1);
        alu_case(7'h00, 3'b011, 2, 1, 32'd0);
        prog.push_back(i_type(3'b101, 3, 2, 'h403));
        store_reg(3, $signed(vb) >>> 3);
        prog.push_back(i_type(3'b111, 3, 2, 'h0f0));
        store_reg(3, vb & 32'h0f0);
        // Dependent chain, no gap between producer and consumer
        prog.push_back(i_type(3'b000, 4, 1, 7));
        prog.push_back(r_type(7'h00, 3'b000, 5, 4, 4));
        store_reg(5, (va + 7) * 2);
        taken_skip(3'b000, 1, 1);
        store_reg(1, va);
        taken_skip(3'b100, 2, 1);
        store_reg(2, vb);
        prog.push_back(b_type(3'b001, 1, 1, 12));
        store_reg(1, va);
        store_reg(2, vb);
        prog.push_back(b_type(3'b101, 2, 1, 12));
        store_reg(2, vb);
        store_reg(1, va);
        at = prog.size() * 4;
        prog.push_back(jal_word(8, 8));
        prog.push_back(s_type(10, 3, 'h200));
        store_reg(8, 32'(at + 4));
        prog.push_back(i_type(3'b000, 0, 0, 123));
        store_reg(0, 32'd0);
    endtask

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(input logic [rv_pkg::xlen-1:0] got,
        input logic [rv_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] mem_wr_addr got 0x%08h expected 0x%08h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input logic [rv_pkg::xlen-1:0] got,
        input logic [rv_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] mem_wr_data got 0x%08h expected 0x%08h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input logic [rv_pkg::xlen-1:0] got,
        input logic [rv_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] pc got 0x%08h expected 0x%08h", got, exp);
            abort_run();
        end
    endtask

    // pc only moves on a rising edge, so the word follows in the same step
    always @(pc or arst_n) begin
        if (!arst_n)
            instr <= rv_pkg::nop_instr;
        else
            instr <= word_at(pc);
    end

    initial begin
        int waited;
        void'($urandom(3));
        build_program();
        // Registers take their reset values at the first edge
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_pc(pc, rv_pkg::reset_pc);
            if (mem_wr_en !== 1'b0) begin
                $display("A store appeared while reset was held");
                abort_run();
            end
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_pc(pc, rv_pkg::reset_pc);
        for (int i = 0; i < exp_addr.size(); i++) begin
            waited = 0;
            @(negedge clk);
            while (mem_wr_en !== 1'b1) begin
                if (waited == store_timeout) begin
                    $display("Timed out waiting for store %0d of %0d", i, exp_addr.size());
                    abort_run();
                end
                waited++;
                @(negedge clk);
            end
            check_addr(mem_wr_addr, exp_addr[i]);
            check_data(mem_wr_data, exp_data[i]);
        end
        repeat (20) begin
            @(negedge clk);
            if (mem_wr_en !== 1'b0) begin
                $display("Unexpected extra store to address 0x%08h", mem_wr_addr);
                abort_run();
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
